//--- arbiter/grant_sequencer.sv
module grant_sequencer (
    input  logic                  clk,
    input  logic                  resetn,
    input  arb_pkg::master_mask_t i_m_awvalid,
    grant_if.seq                  grant
);

    arb_pkg::arb_state_e   state;
    arb_pkg::master_mask_t pending;     // Requests of the current round
    arb_pkg::master_mask_t done_mask;   // Bit of the granted master
    arb_pkg::master_mask_t remaining;
    arb_pkg::master_idx_t  lowest;

    //////////////////////////////////////////////////////////////////////
    // Lowest pending master
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        lowest = '0;
        // Walk down so the lowest set bit is the last one written
        for (int i = arb_pkg::NUM_MASTERS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest = arb_pkg::master_idx_t'(i);
            end
        end
    end

    assign done_mask = arb_pkg::master_mask_t'(1) << grant.idx;
    assign remaining = pending & ~done_mask;

    //////////////////////////////////////////////////////////////////////
    // Round FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state        <= arb_pkg::ARB_IDLE;
            pending      <= '0;
            grant.active <= 1'b0;
            grant.idx    <= '0;
            grant.start  <= 1'b0;
        end else begin
            grant.start <= 1'b0;    // Single-cycle pulse
            case (state)
                arb_pkg::ARB_IDLE: begin
                    if (|i_m_awvalid) begin
                        pending <= i_m_awvalid;     // Snapshot closes the round
                        state   <= arb_pkg::ARB_PICK;
                    end
                end
                arb_pkg::ARB_PICK: begin
                    // Entered only with at least one pending master
                    grant.idx    <= lowest;
                    grant.active <= 1'b1;
                    grant.start  <= 1'b1;
                    state        <= arb_pkg::ARB_SERVE;
                end
                arb_pkg::ARB_SERVE: begin
                    // Response or timeout both retire the master for this round
                    if (grant.b_done || grant.expired) begin
                        grant.active <= 1'b0;
                        pending      <= remaining;
                        if (remaining == '0) begin
                            state <= arb_pkg::ARB_IDLE;
                        end else begin
                            state <= arb_pkg::ARB_PICK;
                        end
                    end
                end
                default: begin
                    state <= arb_pkg::ARB_IDLE;
                end
            endcase
        end
    end

endmodule

//--- arbiter/quantum_timer.sv
module quantum_timer (
    input  logic clk,
    input  logic resetn,
    grant_if.tmr grant
);

    arb_pkg::quantum_cnt_t cnt;     // Cycles since start of grant

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (grant.start) begin
            cnt <= arb_pkg::quantum_cnt_t'(1);  // Start cycle is cycle 0
        end else if (!grant.active) begin
            cnt <= '0;                          // Cleared between grants
        end else if (cnt != arb_pkg::quantum_cnt_t'(arb_pkg::QUANTUM_CYCLES)) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Saturated count marks the end of the quantum; the grant drops on the
    // same edge so this is high for one cycle only
    assign grant.expired = grant.active &&
                           (cnt == arb_pkg::quantum_cnt_t'(arb_pkg::QUANTUM_CYCLES));

endmodule

//--- arbiter/write_channel_mux.sv
module write_channel_mux (
    grant_if.mux                                         grant,
    // Master side
    input  arb_pkg::master_mask_t                        i_m_awvalid,
    input  arb_pkg::addr_t [arb_pkg::NUM_MASTERS-1:0]    i_m_awaddr,
    input  arb_pkg::prot_t [arb_pkg::NUM_MASTERS-1:0]    i_m_awprot,
    input  arb_pkg::master_mask_t                        i_m_wvalid,
    input  arb_pkg::data_t [arb_pkg::NUM_MASTERS-1:0]    i_m_wdata,
    input  arb_pkg::strb_t [arb_pkg::NUM_MASTERS-1:0]    i_m_wstrb,
    input  arb_pkg::master_mask_t                        i_m_bready,
    output arb_pkg::master_mask_t                        o_m_awready,
    output arb_pkg::master_mask_t                        o_m_wready,
    output arb_pkg::master_mask_t                        o_m_bvalid,
    // Slave side
    output logic                                         o_s_awvalid,
    output arb_pkg::addr_t                               o_s_awaddr,
    output arb_pkg::prot_t                               o_s_awprot,
    output logic                                         o_s_wvalid,
    output arb_pkg::data_t                               o_s_wdata,
    output arb_pkg::strb_t                               o_s_wstrb,
    output logic                                         o_s_bready,
    input  logic                                         i_s_awready,
    input  logic                                         i_s_wready,
    input  logic                                         i_s_bvalid
);

    always_comb begin
        // Nothing moves without a grant
        o_s_awvalid = 1'b0;
        o_s_awaddr  = '0;
        o_s_awprot  = '0;
        o_s_wvalid  = 1'b0;
        o_s_wdata   = '0;
        o_s_wstrb   = '0;
        o_s_bready  = 1'b0;
        o_m_awready = '0;
        o_m_wready  = '0;
        o_m_bvalid  = '0;

        if (grant.active) begin
            for (int i = 0; i < arb_pkg::NUM_MASTERS; i++) begin
                if (grant.idx == arb_pkg::master_idx_t'(i)) begin
                    // Forward path
                    o_s_awvalid = i_m_awvalid[i];
                    o_s_awaddr  = i_m_awaddr[i];
                    o_s_awprot  = i_m_awprot[i];
                    o_s_wvalid  = i_m_wvalid[i];
                    o_s_wdata   = i_m_wdata[i];
                    o_s_wstrb   = i_m_wstrb[i];
                    o_s_bready  = i_m_bready[i];
                    // Return path, granted bit only
                    o_m_awready[i] = i_s_awready;
                    o_m_wready[i]  = i_s_wready;
                    o_m_bvalid[i]  = i_s_bvalid;
                end
            end
        end
    end

    assign grant.b_done = i_s_bvalid && o_s_bready;    // o_s_bready already gated

endmodule

//--- bench/axi_wr_arbiter_asserts.sv
module axi_wr_arbiter_asserts (
    input logic                  clk,
    input logic                  resetn,
    input arb_pkg::master_mask_t o_m_awready,
    input arb_pkg::master_mask_t o_m_wready,
    input arb_pkg::master_mask_t o_m_bvalid,
    input logic                  o_s_awvalid,
    input logic                  o_s_wvalid,
    input logic                  o_s_bready,
    input logic                  active
);

    // Only the granted master may see a ready or a response
    a_awready_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(o_m_awready)) else $error("o_m_awready has more than one bit set");

    a_bvalid_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(o_m_bvalid)) else $error("o_m_bvalid has more than one bit set");

    a_awvalid_granted: assert property (@(posedge clk) disable iff (!resetn)
        o_s_awvalid |-> active) else $error("o_s_awvalid high without a grant");

    a_reset_quiet: assert property (@(posedge clk)
        !resetn |-> !(|{o_m_awready, o_m_wready, o_m_bvalid,
                        o_s_awvalid, o_s_wvalid, o_s_bready, active}))
        else $error("output high during reset");

endmodule

bind axi_wr_arbiter axi_wr_arbiter_asserts u_axi_wr_arbiter_asserts (
    .clk         (clk),
    .resetn      (resetn),
    .o_m_awready (o_m_awready),
    .o_m_wready  (o_m_wready),
    .o_m_bvalid  (o_m_bvalid),
    .o_s_awvalid (o_s_awvalid),
    .o_s_wvalid  (o_s_wvalid),
    .o_s_bready  (o_s_bready),
    .active      (u_grant_if.active)
);

//--- bench/tb_axi_wr_arbiter.sv
module tb_axi_wr_arbiter;

    typedef int idx_q_t[$];

    localparam int MAX_CYCLES = 2000;   // Six tests at worst-case quantum, with margin

    logic clk;
    logic resetn;

    arb_pkg::master_mask_t                     m_awvalid;
    arb_pkg::addr_t [arb_pkg::NUM_MASTERS-1:0] m_awaddr;
    arb_pkg::prot_t [arb_pkg::NUM_MASTERS-1:0] m_awprot;
    arb_pkg::master_mask_t                     m_wvalid;
    arb_pkg::data_t [arb_pkg::NUM_MASTERS-1:0] m_wdata;
    arb_pkg::strb_t [arb_pkg::NUM_MASTERS-1:0] m_wstrb;
    arb_pkg::master_mask_t                     m_bready;
    arb_pkg::master_mask_t                     o_m_awready;
    arb_pkg::master_mask_t                     o_m_wready;
    arb_pkg::master_mask_t                     o_m_bvalid;

    logic           o_s_awvalid;
    arb_pkg::addr_t o_s_awaddr;
    arb_pkg::prot_t o_s_awprot;
    logic           o_s_wvalid;
    arb_pkg::data_t o_s_wdata;
    arb_pkg::strb_t o_s_wstrb;
    logic           o_s_bready;
    logic           s_awready;
    logic           s_wready;
    logic           s_bvalid;

    integer seed = 90896;
    int     checks;
    int     errors;
    int     cycles;
    int     txn_cnt  [arb_pkg::NUM_MASTERS];
    int     seen_cnt [arb_pkg::NUM_MASTERS];
    int     b_count  [arb_pkg::NUM_MASTERS];
    bit     withhold_b;     // Slave drops the response of master 0
    bit     watch_m1;       // Master 1 must stay quiet

    int             exp_q[$];   // Expected service order
    arb_pkg::addr_t obs_addr[$];
    arb_pkg::data_t obs_data[$];
    arb_pkg::strb_t obs_strb[$];
    arb_pkg::prot_t obs_prot[$];

    axi_wr_arbiter u_axi_wr_arbiter (
        .clk         (clk),
        .resetn      (resetn),
        .i_m_awvalid (m_awvalid),
        .o_m_awready (o_m_awready),
        .i_m_awaddr  (m_awaddr),
        .i_m_awprot  (m_awprot),
        .i_m_wvalid  (m_wvalid),
        .o_m_wready  (o_m_wready),
        .i_m_wdata   (m_wdata),
        .i_m_wstrb   (m_wstrb),
        .o_m_bvalid  (o_m_bvalid),
        .i_m_bready  (m_bready),
        .o_s_awvalid (o_s_awvalid),
        .i_s_awready (s_awready),
        .o_s_awaddr  (o_s_awaddr),
        .o_s_awprot  (o_s_awprot),
        .o_s_wvalid  (o_s_wvalid),
        .i_s_wready  (s_wready),
        .o_s_wdata   (o_s_wdata),
        .o_s_wstrb   (o_s_wstrb),
        .i_s_bvalid  (s_bvalid),
        .o_s_bready  (o_s_bready)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Payload scheme and reference
    //////////////////////////////////////////////////////////////////////
    function automatic arb_pkg::addr_t addr_of(input int m, input int cnt);
        return arb_pkg::addr_t'((m + 1) << 28) | arb_pkg::addr_t'(cnt * 4);
    endfunction

    function automatic arb_pkg::data_t data_of(input int m, input int cnt);
        return 32'hC0DE_0000 | arb_pkg::data_t'(m << 12) | arb_pkg::data_t'(cnt);
    endfunction

    function automatic arb_pkg::strb_t strb_of(input int m);
        return arb_pkg::strb_t'(4'hF >> m);
    endfunction

    // Ascending indices of the set bits of a round's mask
    function automatic idx_q_t service_order(input arb_pkg::master_mask_t mask);
        idx_q_t order;
        for (int i = 0; i < arb_pkg::NUM_MASTERS; i++) begin
            if (mask[i]) begin
                order.push_back(i);
            end
        end
        return order;
    endfunction

    task automatic queue_round(input arb_pkg::master_mask_t mask);
        idx_q_t order;
        order = service_order(mask);
        foreach (order[i]) begin
            exp_q.push_back(order[i]);
        end
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Master model
    //////////////////////////////////////////////////////////////////////
    task automatic master_write(input int m, input bit expect_b);
        bit aw_done;
        bit w_done;
        int cnt;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cnt     = txn_cnt[m];
        txn_cnt[m]++;
        @(posedge clk);
        m_awvalid[m] <= 1'b1;
        m_awaddr[m]  <= addr_of(m, cnt);
        m_awprot[m]  <= arb_pkg::prot_t'(m);
        m_wvalid[m]  <= 1'b1;
        m_wdata[m]   <= data_of(m, cnt);
        m_wstrb[m]   <= strb_of(m);
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (!aw_done && o_m_awready[m]) begin
                aw_done = 1'b1;
                m_awvalid[m] <= 1'b0;
            end
            if (!w_done && o_m_wready[m]) begin
                w_done = 1'b1;
                m_wvalid[m] <= 1'b0;
            end
        end
        if (expect_b) begin
            do @(posedge clk); while (!o_m_bvalid[m]);   // bready held high
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Slave model, AW then W with random delays
    //////////////////////////////////////////////////////////////////////
    initial begin : slave_model
        int             delay;
        arb_pkg::addr_t a;
        arb_pkg::prot_t p;
        forever begin
            @(posedge clk);
            if (resetn && o_s_awvalid) begin
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                s_awready <= 1'b1;
                @(posedge clk);
                a = o_s_awaddr;
                p = o_s_awprot;
                s_awready <= 1'b0;
                while (!o_s_wvalid) @(posedge clk);
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                s_wready <= 1'b1;
                @(posedge clk);
                obs_addr.push_back(a);
                obs_prot.push_back(p);
                obs_data.push_back(o_s_wdata);
                obs_strb.push_back(o_s_wstrb);
                s_wready <= 1'b0;
                if (!(withhold_b && a[31:28] == 4'd1)) begin
                    s_bvalid <= 1'b1;
                    @(posedge clk);
                    while (!o_s_bready) @(posedge clk);
                    s_bvalid <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Monitors and comparison
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : b_monitor
        for (int m = 0; m < arb_pkg::NUM_MASTERS; m++) begin
            if (o_m_bvalid[m] && m_bready[m]) begin
                b_count[m]++;
            end
        end
        if (watch_m1) begin
            check({o_m_awready[1], o_m_wready[1], o_m_bvalid[1]}, 0, "master 1 outputs");
        end
    end

    always @(posedge clk) begin : compare_proc
        int m;
        int exp_m;
        while (obs_addr.size() > 0) begin
            m = int'(obs_addr[0][31:28]) - 1;   // Address base names the master
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected transaction at the slave at %0t", $time);
                exp_m = m;
            end else begin
                exp_m = exp_q.pop_front();
            end
            check(m, exp_m, "service order");
            check(obs_addr[0], addr_of(exp_m, seen_cnt[exp_m]), "awaddr");
            check(obs_prot[0], exp_m, "awprot");
            check(obs_data[0], data_of(exp_m, seen_cnt[exp_m]), "wdata");
            check(obs_strb[0], strb_of(exp_m), "wstrb");
            seen_cnt[exp_m]++;
            void'(obs_addr.pop_front());
            void'(obs_prot.pop_front());
            void'(obs_data.pop_front());
            void'(obs_strb.pop_front());
        end
    end

    always @(posedge clk) begin : timeout
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_quiet(input string msg);
        check({o_m_awready, o_m_wready, o_m_bvalid}, 0, {msg, " master side"});
        check({o_s_awvalid, o_s_wvalid, o_s_bready}, 0, {msg, " slave side"});
    endtask

    task automatic check_b(input int b0, input int b1, input int b2, input string msg);
        @(negedge clk);     // Monitors have taken the last edge
        while (obs_addr.size() != 0) @(negedge clk);
        check(b_count[0], b0, {msg, " bvalid count m0"});
        check(b_count[1], b1, {msg, " bvalid count m1"});
        check(b_count[2], b2, {msg, " bvalid count m2"});
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        m_awvalid  = '0;
        m_awaddr   = '0;
        m_awprot   = '0;
        m_wvalid   = '0;
        m_wdata    = '0;
        m_wstrb    = '0;
        m_bready   = '1;
        s_awready  = 1'b0;
        s_wready   = 1'b0;
        s_bvalid   = 1'b0;
        withhold_b = 1'b0;
        watch_m1   = 1'b0;

        // Reset state
        repeat (3) begin
            @(posedge clk);
            check_quiet("in reset");
        end
        resetn <= 1'b1;
        @(posedge clk);
        check_quiet("after reset");

        // Single request
        queue_round(3'b010);
        master_write(1, 1'b1);
        check_b(0, 1, 0, "single");

        // Full round
        queue_round(3'b111);
        fork
            master_write(0, 1'b1);
            master_write(1, 1'b1);
            master_write(2, 1'b1);
        join
        check_b(1, 2, 1, "full round");

        // Partial mask
        queue_round(3'b101);
        watch_m1 = 1'b1;
        fork
            master_write(0, 1'b1);
            master_write(2, 1'b1);
        join
        check_b(2, 2, 2, "partial");
        watch_m1 = 1'b0;

        // Late request joins the next round
        queue_round(3'b100);
        queue_round(3'b001);
        fork
            master_write(2, 1'b1);
            begin
                repeat (2) @(posedge clk);
                master_write(0, 1'b1);
            end
        join
        check_b(3, 2, 3, "late");

        // Quantum timeout on master 0
        withhold_b = 1'b1;
        queue_round(3'b011);
        fork
            master_write(0, 1'b0);
            master_write(1, 1'b1);
        join
        check_b(3, 3, 3, "timeout");
        withhold_b = 1'b0;
        check(exp_q.size(), 0, "transactions left unserved");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- common/arb_pkg.sv
package arb_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////
    localparam int NUM_MASTERS    = 3;
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = DATA_W / 8;
    localparam int QUANTUM_CYCLES = 16;     // Longest grant in cycles

    //////////////////////////////////////////////////////////////////////
    // Bus fields
    //////////////////////////////////////////////////////////////////////
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [STRB_W-1:0]      strb_t;
    typedef logic [2:0]             prot_t;

    // Arbitration bookkeeping
    typedef logic [NUM_MASTERS-1:0] master_mask_t;  // One bit per master
    typedef logic [1:0]             master_idx_t;
    typedef logic [4:0]             quantum_cnt_t;  // Must reach QUANTUM_CYCLES

    typedef enum logic [1:0] {
        ARB_IDLE,   // Waiting for a request
        ARB_PICK,   // Choosing next pending master
        ARB_SERVE   // Grant in flight
    } arb_state_e;

endpackage

//--- common/grant_if.sv
interface grant_if;

    logic                 active;   // A master holds the grant
    logic                 start;    // First cycle of a grant
    arb_pkg::master_idx_t idx;      // Granted master
    logic                 b_done;   // Granted master's B handshake
    logic                 expired;  // Quantum used up

    // Sequencer owns the grant
    modport seq (
        output active,
        output idx,
        output start,
        input  b_done,
        input  expired
    );

    // Channel routing
    modport mux (
        input  active,
        input  idx,
        output b_done
    );

    modport tmr (
        input  active,
        input  start,
        output expired
    );

endinterface

//--- compile.f
common/arb_pkg.sv
common/grant_if.sv
arbiter/grant_sequencer.sv
arbiter/quantum_timer.sv
arbiter/write_channel_mux.sv
src/axi_wr_arbiter.sv
bench/axi_wr_arbiter_asserts.sv
bench/tb_axi_wr_arbiter.sv

//--- run.sh
#!/bin/sh
# Build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_axi_wr_arbiter -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_axi_wr_arbiter)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

//--- src/axi_wr_arbiter.sv
module axi_wr_arbiter (
    input  logic                                         clk,
    input  logic                                         resetn,

    //////////////////////////////////////////////////////////////////////
    // Masters
    //////////////////////////////////////////////////////////////////////
    input  arb_pkg::master_mask_t                        i_m_awvalid,
    output arb_pkg::master_mask_t                        o_m_awready,
    input  arb_pkg::addr_t [arb_pkg::NUM_MASTERS-1:0]    i_m_awaddr,
    input  arb_pkg::prot_t [arb_pkg::NUM_MASTERS-1:0]    i_m_awprot,
    input  arb_pkg::master_mask_t                        i_m_wvalid,
    output arb_pkg::master_mask_t                        o_m_wready,
    input  arb_pkg::data_t [arb_pkg::NUM_MASTERS-1:0]    i_m_wdata,
    input  arb_pkg::strb_t [arb_pkg::NUM_MASTERS-1:0]    i_m_wstrb,
    output arb_pkg::master_mask_t                        o_m_bvalid,
    input  arb_pkg::master_mask_t                        i_m_bready,

    //////////////////////////////////////////////////////////////////////
    // Slave
    //////////////////////////////////////////////////////////////////////
    output logic                                         o_s_awvalid,
    input  logic                                         i_s_awready,
    output arb_pkg::addr_t                               o_s_awaddr,
    output arb_pkg::prot_t                               o_s_awprot,
    output logic                                         o_s_wvalid,
    input  logic                                         i_s_wready,
    output arb_pkg::data_t                               o_s_wdata,
    output arb_pkg::strb_t                               o_s_wstrb,
    input  logic                                         i_s_bvalid,
    output logic                                         o_s_bready
);

    grant_if u_grant_if ();     // Shared grant state

    grant_sequencer u_grant_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .i_m_awvalid (i_m_awvalid),
        .grant       (u_grant_if.seq)
    );

    quantum_timer u_quantum_timer (
        .clk    (clk),
        .resetn (resetn),
        .grant  (u_grant_if.tmr)
    );

    write_channel_mux u_write_channel_mux (
        .grant       (u_grant_if.mux),
        .i_m_awvalid (i_m_awvalid),
        .i_m_awaddr  (i_m_awaddr),
        .i_m_awprot  (i_m_awprot),
        .i_m_wvalid  (i_m_wvalid),
        .i_m_wdata   (i_m_wdata),
        .i_m_wstrb   (i_m_wstrb),
        .i_m_bready  (i_m_bready),
        .o_m_awready (o_m_awready),
        .o_m_wready  (o_m_wready),
        .o_m_bvalid  (o_m_bvalid),
        .o_s_awvalid (o_s_awvalid),
        .o_s_awaddr  (o_s_awaddr),
        .o_s_awprot  (o_s_awprot),
        .o_s_wvalid  (o_s_wvalid),
        .o_s_wdata   (o_s_wdata),
        .o_s_wstrb   (o_s_wstrb),
        .o_s_bready  (o_s_bready),
        .i_s_awready (i_s_awready),
        .i_s_wready  (i_s_wready),
        .i_s_bvalid  (i_s_bvalid)
    );

endmodule
